// ==== all.f ====
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/ctrl_decode.sv
logic/branch_resolve.sv
logic/id_ex_stage.sv
logic/decode_top.sv
bench/decode_checker.sv
bench/decode_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module decode_tb -Mdir obj_dir

./obj_dir/Vdecode_tb | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_tb import rv_isa_pkg::*, pipe_pkg::*; ();

  localparam int N_INS          = 400;
  localparam int N_RANDOM       = 250;
  localparam int TIMEOUT_CYCLES = 20 * N_INS;

  logic       bus;
  logic       arst_n;
  logic       ins_valid;
  instr_t     ins;
  pc_t        pc;
  reg_idx_t   rs1_addr;
  reg_idx_t   rs2_addr;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  fwd_src_t   ex_mem;
  fwd_src_t   wb;
  logic       credit_return;
  logic       stall;
  logic       branch_taken;
  pc_t        branch_target;
  logic       id_ex_valid;
  id_ex_t     id_ex;
  logic [1:0] phase;
  int         checks;
  int         errors;

  integer     seed = 83499;
  xlen_t      regs [32];
  int         accepted;
  int         cycles;
  int         q_cnt;
  int         phase_cycles;
  logic       held;
  pc_t        next_pc;

  // Register file read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  decode_top uut (.*);

  decode_checker u_chk (.*);

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  // Small signed values so that compares often come out equal
  function automatic xlen_t small_val();
    integer r;
    r = $random(seed);
    return {{29{r[2]}}, r[2:0]};
  endfunction

  function automatic instr_t random_ins();
    instr_t  w;
    opcode_t opc;
    integer  r;
    int      k;
    w = $random(seed);
    r = $random(seed);
    opc = opc.first();
    repeat (r[7:0] % 9)
      opc = opc.next();
    w[6:0]   = opc;
    // Registers x0..x7 only, so dependencies are common
    w[11:7]  = {2'b00, r[10:8]};
    w[19:15] = {2'b00, r[13:11]};
    w[24:20] = {2'b00, r[16:14]};
    k = r[23:20] % 6;
    if (opc == OPC_BRANCH) begin
      w[14:12] = (k < 2) ? 3'(k) : 3'(k + 2);
    end
    if (opc == OPC_JALR) begin
      w[14:12] = 3'b000;
    end
    return w;
  endfunction

  function automatic fwd_src_t random_fwd();
    fwd_src_t f;
    integer   r;
    r = $random(seed);
    f.valid = r[0];
    f.rd    = {2'b00, r[3:1]};
    f.data  = small_val();
    return f;
  endfunction

  ////////////////////
  // Fetch, forwarding and execute models
  ////////////////////
  task automatic drive_inputs();
    integer r;
    logic   drain;
    r = $random(seed);
    // Fetch holds the word while decode stalls
    if (!held) begin
      ins_valid = r[2:0] != 3'b000;
      ins       = (r[7:4] == 4'h0) ? '0 : random_ins();
      pc        = next_pc;
    end
    ex_mem = random_fwd();
    wb     = random_fwd();
    regs[5'(1 + r[12:10] % 7)] = small_val();
    // Execute queue stops draining for 20 of every 40 cycles in phase 2
    if (phase == 2'd2) begin
      phase_cycles++;
      drain = (phase_cycles % 40) >= 20 && r[15];
    end else begin
      drain = r[15:14] != 2'b00;
    end
    credit_return = (q_cnt > 0) && drain;
  endtask

  task automatic sample_outputs();
    held = ins_valid && stall;
    if (ins_valid && !stall) begin
      accepted++;
      next_pc = branch_taken ? branch_target : pc + 16'd4;
    end
    q_cnt = q_cnt + (id_ex_valid ? 1 : 0) - (credit_return ? 1 : 0);
  endtask

  initial begin
    arst_n        = 1'b0;
    ins_valid     = 1'b0;
    ins           = '0;
    pc            = '0;
    ex_mem        = '0;
    wb            = '0;
    credit_return = 1'b0;
    phase         = 2'd0;
    held          = 1'b0;
    next_pc       = '0;
    accepted      = 0;
    q_cnt         = 0;
    phase_cycles  = 0;
    regs[0]       = '0;
    for (int i = 1; i < 32; i++) begin
      regs[i] = small_val();
    end
    repeat (4) @(posedge bus);
    #1;
    arst_n = 1'b1;
    @(posedge bus);
    #1;
    phase = 2'd1;
    while (accepted < N_INS) begin
      if (accepted >= N_RANDOM) begin
        phase = 2'd2;
      end
      drive_inputs();
      @(negedge bus);
      sample_outputs();
      @(posedge bus);
      #1;
    end
    phase         = 2'd3;
    ins_valid     = 1'b0;
    credit_return = 1'b0;
    repeat (2) @(negedge bus);
    #1;
    $display("Done: %0d instructions accepted, %0d checks, %0d errors",
             accepted, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge bus);
      cycles++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d instructions accepted",
             cycles, accepted, N_INS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/decode_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_checker import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic       bus,
  input  logic       arst_n,
  input  logic [1:0] phase,
  input  logic       ins_valid,
  input  instr_t     ins,
  input  pc_t        pc,
  input  xlen_t      rs1_data,
  input  xlen_t      rs2_data,
  input  fwd_src_t   ex_mem,
  input  fwd_src_t   wb,
  input  logic       credit_return,
  input  reg_idx_t   rs1_addr,
  input  reg_idx_t   rs2_addr,
  input  logic       stall,
  input  logic       branch_taken,
  input  pc_t        branch_target,
  input  logic       id_ex_valid,
  input  id_ex_t     id_ex,
  output int         checks,
  output int         errors
);

  int         m_credits;
  logic       m_valid;
  logic       m_flush;
  id_ex_t     m_rec;
  logic [1:0] last_phase;
  int         n_rec;
  int         n_stall;
  int         n_taken;
  int         n_flush;
  int         n_err;

  initial begin
    checks     = 0;
    errors     = 0;
    last_phase = 2'd0;
    n_rec      = 0;
    n_stall    = 0;
    n_taken    = 0;
    n_flush    = 0;
    n_err      = 0;
  end

  // RV32I ALU operation for OP and OP-IMM
  function automatic alu_op_t arith_op(logic [2:0] f3, logic bit30, logic is_reg);
    case (f3)
      3'd0:    return (is_reg && bit30) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return bit30 ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic ctrl_t expect_ctrl(instr_t w);
    ctrl_t c;
    logic  is_ld;
    logic  is_st;
    logic  is_br;
    logic  is_op;
    logic  is_opi;
    logic  legal;
    is_ld  = w[6:0] == OPC_LOAD;
    is_st  = w[6:0] == OPC_STORE;
    is_br  = w[6:0] == OPC_BRANCH;
    is_op  = w[6:0] == OPC_REG;
    is_opi = w[6:0] == OPC_IMM;
    c       = '0;
    c.lui   = w[6:0] == OPC_LUI;
    c.auipc = w[6:0] == OPC_AUIPC;
    c.jal   = w[6:0] == OPC_JAL;
    c.jalr  = w[6:0] == OPC_JALR;
    legal = c.lui || c.auipc || c.jal || c.jalr || is_ld || is_st || is_br || is_op || is_opi;
    c.branch      = is_br;
    c.mem_read    = is_ld;
    c.mem_write   = is_st;
    c.reg_write   = legal && !is_br && !is_st;
    c.alu_src_imm = legal && !is_op && !is_br && !c.jal;
    c.mem_size    = (is_ld || is_st) ? w[14:12] : 3'b000;
    c.funct3      = legal ? w[14:12] : 3'b000;
    if (c.lui) begin
      c.alu_op = ALU_PASS_B;
    end else if (is_br) begin
      c.alu_op = ALU_SUB;
    end else if (is_op || is_opi) begin
      c.alu_op = arith_op(w[14:12], w[30], is_op);
    end else begin
      c.alu_op = ALU_ADD;
    end
    return c;
  endfunction

  function automatic xlen_t expect_imm(instr_t w);
    case (w[6:0])
      OPC_IMM, OPC_LOAD, OPC_JALR: return {{20{w[31]}}, w[31:20]};
      OPC_STORE:                   return {{20{w[31]}}, w[31:25], w[11:7]};
      OPC_BRANCH:                  return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC:          return {w[31:12], 12'h000};
      OPC_JAL:                     return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:                     return '0;
    endcase
  endfunction

  // EX/MEM is younger than WB, x0 stays zero
  function automatic xlen_t operand(reg_idx_t rs, xlen_t reg_val);
    if (rs == 5'd0) begin
      return reg_val;
    end
    if (ex_mem.valid && ex_mem.rd == rs) begin
      return ex_mem.data;
    end
    if (wb.valid && wb.rd == rs) begin
      return wb.data;
    end
    return reg_val;
  endfunction

  function automatic logic branch_cond(logic [2:0] f3, xlen_t a, xlen_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [159:0] got, input logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      n_err++;
      $display("FAIL %s: got %0h expected %0h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic report_group(input logic [1:0] grp);
    string name;
    case (grp)
      2'd0:    name = "reset";
      2'd1:    name = "random stream";
      default: name = "credit back-pressure";
    endcase
    $display("Test %s done: %0d records, %0d stalls, %0d redirects, %0d flushed, %0d errors",
             name, n_rec, n_stall, n_taken, n_flush, n_err);
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  always @(negedge bus) begin : model
    ctrl_t    c;
    xlen_t    imm;
    xlen_t    a;
    xlen_t    b;
    reg_idx_t s1;
    reg_idx_t s2;
    pc_t      tgt;
    logic     v;
    logic     use1;
    logic     use2;
    logic     dep1;
    logic     dep2;
    logic     taken;
    logic     load_use;
    logic     br_dep;
    logic     acc;
    logic     iss;
    if (phase != last_phase) begin
      report_group(last_phase);
      last_phase = phase;
      n_rec      = 0;
      n_stall    = 0;
      n_taken    = 0;
      n_flush    = 0;
      n_err      = 0;
    end
    if (!arst_n) begin
      m_credits = ID_EX_CREDITS;
      m_valid   = 1'b0;
      m_flush   = 1'b0;
      compare("id_ex_valid", id_ex_valid, 1'b0);
      compare("stall", stall, 1'b0);
      compare("branch_taken", branch_taken, 1'b0);
    end else begin
      c   = expect_ctrl(ins);
      imm = expect_imm(ins);
      s1  = ins[19:15];
      s2  = ins[24:20];
      a   = operand(s1, rs1_data);
      b   = operand(s2, rs2_data);
      // Every supported opcode sets at least one control bit
      v = ins_valid && c != '0;
      // Register operands by instruction format
      use1 = c != '0 && !c.lui && !c.auipc && !c.jal;
      use2 = ins[6:0] == OPC_REG || ins[6:0] == OPC_STORE || ins[6:0] == OPC_BRANCH;
      dep1 = c.branch || c.jalr;
      dep2 = c.branch;
      taken = c.jal || c.jalr || (c.branch && branch_cond(c.funct3, a, b));
      tgt   = c.jalr ? pc_t'((a + imm) & 32'hffff_fffe) : pc + imm[15:0];
      load_use = m_valid && m_rec.ctrl.mem_read && m_rec.rd != 5'd0
                 && ((use1 && m_rec.rd == s1) || (use2 && m_rec.rd == s2));
      br_dep   = m_valid && m_rec.ctrl.reg_write && m_rec.rd != 5'd0
                 && ((dep1 && m_rec.rd == s1) || (dep2 && m_rec.rd == s2));
      acc = v && !load_use && !br_dep && m_credits > 0;
      iss = acc && !m_flush;
      compare("rs1_addr", rs1_addr, s1);
      compare("rs2_addr", rs2_addr, s2);
      compare("stall", stall, v && !acc);
      compare("branch_taken", branch_taken, iss && taken);
      if (iss && taken) begin
        compare("branch_target", branch_target, tgt);
      end
      compare("id_ex_valid", id_ex_valid, m_valid);
      if (m_valid) begin
        compare("id_ex.ctrl", id_ex.ctrl, m_rec.ctrl);
        compare("id_ex.rs1", id_ex.rs1, m_rec.rs1);
        compare("id_ex.rs2", id_ex.rs2, m_rec.rs2);
        compare("id_ex.rd", id_ex.rd, m_rec.rd);
        compare("id_ex.rs1_data", id_ex.rs1_data, m_rec.rs1_data);
        compare("id_ex.rs2_data", id_ex.rs2_data, m_rec.rs2_data);
        compare("id_ex.imm", id_ex.imm, m_rec.imm);
        compare("id_ex.pc", id_ex.pc, m_rec.pc);
        n_rec++;
      end
      if (v && !acc) begin
        n_stall++;
      end
      if (iss && taken) begin
        n_taken++;
      end
      if (acc && m_flush) begin
        n_flush++;
      end
      // State for the next cycle
      if (iss) begin
        m_rec.ctrl     = c;
        m_rec.rs1      = s1;
        m_rec.rs2      = s2;
        m_rec.rd       = ins[11:7];
        m_rec.rs1_data = rs1_data;
        m_rec.rs2_data = rs2_data;
        m_rec.imm      = imm;
        m_rec.pc       = pc;
      end
      m_valid   = iss;
      m_credits = m_credits - (iss ? 1 : 0) + (credit_return ? 1 : 0);
      if (acc) begin
        m_flush = iss && taken;
      end
      checks++;
      if (m_credits > ID_EX_CREDITS) begin
        errors++;
        n_err++;
        $display("Execute returned a credit with no record outstanding at %0t ns", $time);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/decode_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_top import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic     bus,
  input  logic     arst_n,
  // Fetch and register file
  input  logic     ins_valid,
  input  instr_t   ins,
  input  pc_t      pc,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  // Forwarding sources and execute
  input  fwd_src_t ex_mem,
  input  fwd_src_t wb,
  input  logic     credit_return,
  output logic     stall,
  output logic     branch_taken,
  output pc_t      branch_target,
  output logic     id_ex_valid,
  output id_ex_t   id_ex
);

  ctrl_t    ctrl;
  xlen_t    imm;
  reg_idx_t rd;
  logic     illegal;
  logic     dec_valid;
  logic     taken;
  logic     dep_rs1;
  logic     dep_rs2;

  // Unsupported words pass as bubbles
  assign dec_valid = ins_valid && !illegal;

  ctrl_decode u_ctrl (
    .ins     (ins),
    .ctrl    (ctrl),
    .imm     (imm),
    .rs1     (rs1_addr),
    .rs2     (rs2_addr),
    .rd      (rd),
    .illegal (illegal)
  );

  branch_resolve u_branch (
    .ctrl     (ctrl),
    .imm      (imm),
    .pc       (pc),
    .rs1      (rs1_addr),
    .rs2      (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex_mem   (ex_mem),
    .wb       (wb),
    .taken    (taken),
    .target   (branch_target),
    .dep_rs1  (dep_rs1),
    .dep_rs2  (dep_rs2)
  );

  id_ex_stage u_stage (
    .bus           (bus),
    .arst_n        (arst_n),
    .ins_valid     (dec_valid),
    .ctrl          (ctrl),
    .imm           (imm),
    .pc            (pc),
    .rs1           (rs1_addr),
    .rs2           (rs2_addr),
    .rd            (rd),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .taken         (taken),
    .dep_rs1       (dep_rs1),
    .dep_rs2       (dep_rs2),
    .credit_return (credit_return),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .id_ex_valid   (id_ex_valid),
    .id_ex         (id_ex)
  );

endmodule

`default_nettype wire

// ==== logic/id_ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_stage import rv_isa_pkg::*, pipe_pkg::*; (
  input  logic     bus,
  input  logic     arst_n,
  input  logic     ins_valid,
  input  ctrl_t    ctrl,
  input  xlen_t    imm,
  input  pc_t      pc,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  input  logic     taken,
  input  logic     dep_rs1,
  input  logic     dep_rs2,
  input  logic     credit_return,
  output logic     stall,
  output logic     branch_taken,
  output logic     id_ex_valid,
  output id_ex_t   id_ex
);

  credit_t credits;
  logic    flush_q;
  logic    use_rs1;
  logic    use_rs2;
  logic    load_use;
  logic    br_hazard;
  logic    accept;
  logic    issue;

  ////////////////////
  // Hazards
  ////////////////////
  // Operands execute will read
  assign use_rs1 = (ctrl.reg_write && !ctrl.lui && !ctrl.auipc && !ctrl.jal)
                   || ctrl.mem_write || ctrl.branch;
  assign use_rs2 = (ctrl.reg_write && !ctrl.alu_src_imm && !ctrl.jal)
                   || ctrl.mem_write || ctrl.branch;

  // Load data not back in time for the next instruction
  assign load_use = id_ex_valid && id_ex.ctrl.mem_read && id_ex.rd != '0
                    && ((use_rs1 && id_ex.rd == rs1) || (use_rs2 && id_ex.rd == rs2));

  // Decode compares before the previous result reaches a forwarding source
  assign br_hazard = id_ex_valid && id_ex.ctrl.reg_write && id_ex.rd != '0
                     && ((dep_rs1 && id_ex.rd == rs1) || (dep_rs2 && id_ex.rd == rs2));

  assign stall        = ins_valid && (load_use || br_hazard || credits == '0);
  assign accept       = ins_valid && !stall;
  assign issue        = accept && !flush_q;
  assign branch_taken = issue && taken;

  ////////////////////
  // Credits and flush
  ////////////////////
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      credits <= credit_t'(ID_EX_CREDITS);
    end else begin
      case ({issue, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_valid <= 1'b0;
      flush_q     <= 1'b0;
    end else begin
      id_ex_valid <= issue;
      // Next accepted word is the wrong-path fetch
      if (accept) begin
        flush_q <= branch_taken;
      end
    end
  end

  // ID/EX record
  always_ff @(posedge bus) begin
    if (issue) begin
      id_ex.ctrl     <= ctrl;
      id_ex.rs1      <= rs1;
      id_ex.rs2      <= rs2;
      id_ex.rd       <= rd;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm      <= imm;
      id_ex.pc       <= pc;
    end
  end

  // Execute never returns more credits than it has queue entries
  a_credit_max: assert property (@(posedge bus) disable iff (!arst_n)
    credits <= credit_t'(ID_EX_CREDITS))
    else $error("credit counter above %0d", ID_EX_CREDITS);

  a_no_credit_issue: assert property (@(posedge bus) disable iff (!arst_n)
    credits == '0 |=> !id_ex_valid)
    else $error("record issued with no credit left");

endmodule

`default_nettype wire

// ==== logic/branch_resolve.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_resolve import rv_isa_pkg::*, pipe_pkg::*; (
  input  ctrl_t    ctrl,
  input  xlen_t    imm,
  input  pc_t      pc,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  xlen_t    rs1_data,
  input  xlen_t    rs2_data,
  input  fwd_src_t ex_mem,
  input  fwd_src_t wb,
  output logic     taken,
  output pc_t      target,
  output logic     dep_rs1,
  output logic     dep_rs2
);

  xlen_t op1;
  xlen_t op2;
  xlen_t jalr_sum;
  logic  cond;

  // Youngest producer wins, x0 never forwards
  function automatic xlen_t fwd_pick(reg_idx_t rs, xlen_t reg_data,
                                     fwd_src_t near_src, fwd_src_t far_src);
    xlen_t val;
    val = reg_data;
    if (rs != '0 && far_src.valid && far_src.rd == rs) begin
      val = far_src.data;
    end
    if (rs != '0 && near_src.valid && near_src.rd == rs) begin
      val = near_src.data;
    end
    return val;
  endfunction

  assign op1 = fwd_pick(rs1, rs1_data, ex_mem, wb);
  assign op2 = fwd_pick(rs2, rs2_data, ex_mem, wb);

  ////////////////////
  // Outcome
  ////////////////////
  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  cond = (op1 == op2);
      F3_BNE:  cond = (op1 != op2);
      F3_BLT:  cond = ($signed(op1) < $signed(op2));
      F3_BGE:  cond = ($signed(op1) >= $signed(op2));
      F3_BLTU: cond = (op1 < op2);
      F3_BGEU: cond = (op1 >= op2);
      default: cond = 1'b0;
    endcase
  end

  // Jumps always redirect
  assign taken = (ctrl.branch && cond) || ctrl.jal || ctrl.jalr;

  // JALR target drops bit 0, then fits the fetch address width
  assign jalr_sum = op1 + imm;
  assign target   = ctrl.jalr ? pc_t'(jalr_sum & ~xlen_t'(1)) : pc + pc_t'(imm);

  // Operands read here in decode
  assign dep_rs1 = ctrl.branch || ctrl.jalr;
  assign dep_rs2 = ctrl.branch;

endmodule

`default_nettype wire

// ==== logic/ctrl_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ctrl_decode import rv_isa_pkg::*; (
  input  instr_t   ins,
  output ctrl_t    ctrl,
  output xlen_t    imm,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output logic     illegal
);

  opcode_t opcode;
  funct3_t funct3;
  logic    funct7_b5;
  xlen_t   imm_i;
  xlen_t   imm_s;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   imm_j;

  // SUB only exists in OP, SRAI shares the funct7 bit with SRA
  function automatic alu_op_t alu_sel(funct3_t f3, logic alt, logic reg_op);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = (alt && reg_op) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = opcode_t'(ins[6:0]);
  assign funct3    = ins[14:12];
  assign funct7_b5 = ins[30];
  assign rd        = ins[11:7];
  assign rs1       = ins[19:15];
  assign rs2       = ins[24:20];

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'b0};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = funct3;
    imm         = '0;
    illegal     = 1'b0;
    case (opcode)
      OPC_LUI: begin
        ctrl.alu_op      = ALU_PASS_B;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.lui         = 1'b1;
        imm              = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.auipc       = 1'b1;
        imm              = imm_u;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        imm            = imm_j;
      end
      OPC_JALR: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.jalr        = 1'b1;
        imm              = imm_i;
      end
      OPC_BRANCH: begin
        ctrl.alu_op = ALU_SUB;
        ctrl.branch = 1'b1;
        imm         = imm_b;
      end
      OPC_LOAD: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_size    = funct3;
        imm              = imm_i;
      end
      OPC_STORE: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
        ctrl.mem_size    = funct3;
        imm              = imm_s;
      end
      OPC_IMM: begin
        ctrl.alu_op      = alu_sel(funct3, funct7_b5, 1'b0);
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
      end
      OPC_REG: begin
        ctrl.alu_op    = alu_sel(funct3, funct7_b5, 1'b1);
        ctrl.reg_write = 1'b1;
      end
      // Also catches the all-zero bubble word
      default: begin
        ctrl    = '0;
        illegal = 1'b1;
      end
    endcase
  end

  // A memory access is either a load or a store
  always_comb begin
    a_mem_excl: assert (!(ctrl.mem_read && ctrl.mem_write))
      else $error("load and store decoded together");
  end

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  import rv_isa_pkg::*;

  // Entries in the execute input queue
  localparam int ID_EX_CREDITS = 2;
  localparam int CREDIT_W      = $clog2(ID_EX_CREDITS + 1);

  typedef logic [CREDIT_W-1:0] credit_t;

  // Result of a later stage that decode may forward from
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xlen_t    data;
  } fwd_src_t;

  // ID/EX pipeline record
  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
    pc_t      pc;
  } id_ex_t;

endpackage

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] xlen_t;
  typedef logic [15:0] pc_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;

  // RV32I major opcodes handled in decode
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_IMM    = 7'b0010011,
    OPC_REG    = 7'b0110011
  } opcode_t;

  ////////////////////
  // funct3 encodings
  ////////////////////
  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // Decoded control, 19 bits
  typedef struct packed {
    alu_op_t      alu_op;
    logic         alu_src_imm;
    logic         mem_read;
    logic         mem_write;
    logic         reg_write;
    logic [2:0]   mem_size;
    logic         branch;
    logic         jal;
    logic         jalr;
    logic         auipc;
    logic         lui;
    funct3_t      funct3;
  } ctrl_t;

endpackage

`default_nettype wire
